// ==== design/lwe_param_pkg.sv ====
/* Widths and constants of the body path. BR_CORR_W must hold the body plus the mean
   fraction, and the accumulated error must fit KS_MAX_ERROR_W for LWE_K terms */
package lwe_param_pkg;

  // Body word and extracted coefficient
  localparam int MOD_KSK_W      = 16;
  localparam int LWE_COEF_W     = 10;

  // One signed mod-switch error and the width of their sum
  localparam int KS_CORR_W      = 4;
  localparam int KS_MAX_ERROR_W = 7;

  // Key mean in fixed point, 0.5 with 4 fraction bits
  localparam int KS_KEY_MEAN_F  = 4;
  localparam int KS_KEY_MEAN    = 8;

  // Compensated word, body shifted up by the mean fraction
  localparam int BR_CORR_W      = MOD_KSK_W + KS_KEY_MEAN_F;

  // Half a step of the 2N modulus, removed from every body
  localparam logic [MOD_KSK_W-1:0] CENTER_CORR = MOD_KSK_W'(1) << (MOD_KSK_W - LWE_COEF_W - 1);

  // Field view of the compensated word, MSB first
  typedef struct packed {
    logic [LWE_COEF_W-1:0]           coef;
    logic                            round_bit;
    logic [BR_CORR_W-LWE_COEF_W-2:0] frac;
  } br_fields_t;

  typedef union packed {
    logic [BR_CORR_W-1:0] word;
    br_fields_t           fields;
  } br_word_u;

endpackage

// ==== design/pbs_slot_pkg.sv ====
/* Slot numbering. PID_W must address PBS_NB_MAX slots, and LWE_K_WW must hold LWE_K */
package pbs_slot_pkg;

  // Largest number of program slots in flight
  localparam int PBS_NB_MAX = 16;
  localparam int PID_W      = 4;

  // Corrections expected per slot before a read may go
  localparam int LWE_K      = 4;
  localparam int LWE_K_WW   = 3;

endpackage

// ==== design/slot_lookup_if.sv ====
/* Lookup is combinational: both stores answer for rd_pid in the same cycle */
`timescale 1ns/10ps

interface slot_lookup_if;

  // Scheduler side
  logic                                     rd_en;
  logic [pbs_slot_pkg::PID_W-1:0]           rd_pid;

  // Body store answer
  logic [lwe_param_pkg::MOD_KSK_W-1:0]      body_data;
  logic                                     body_present;
  logic                                     body_wr_busy;

  // Correction store answer
  logic [lwe_param_pkg::KS_MAX_ERROR_W-1:0] corr_sum;
  logic                                     corr_avail;
  logic                                     corr_wr_busy;

  modport sched (
    output rd_en, rd_pid,
    input  body_data, body_present, body_wr_busy,
    input  corr_sum, corr_avail, corr_wr_busy
  );

  modport body (
    input  rd_en, rd_pid,
    output body_data, body_present, body_wr_busy
  );

  modport corr (
    input  rd_en, rd_pid,
    output corr_sum, corr_avail, corr_wr_busy
  );

endinterface

// ==== design/skid_buffer.sv ====
/* Two-entry valid/ready buffer. in_rdy is registered, so no path runs from out_rdy to in_rdy */
`timescale 1ns/10ps

module skid_buffer #(
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             s_rst_n,
  input  logic [WIDTH-1:0] in_data,
  input  logic             in_vld,
  output logic             in_rdy,
  output logic [WIDTH-1:0] out_data,
  output logic             out_vld,
  input  logic             out_rdy
);

  logic [WIDTH-1:0] main_data;
  logic             main_vld;
  logic [WIDTH-1:0] skid_data;
  logic             skid_vld;
  logic             main_load;

  // Main entry takes a word when empty or draining
  assign main_load = !main_vld || out_rdy;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      main_vld <= 1'b0;
      skid_vld <= 1'b0;
    end else if (main_load) begin
      // Skid entry drains first
      main_vld <= skid_vld || in_vld;
      skid_vld <= 1'b0;
    end else if (in_vld && in_rdy) begin
      skid_vld <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (main_load) begin
      main_data <= skid_vld ? skid_data : in_data;
    end
    // Skid holds its word once it is full
    if (in_rdy) begin
      skid_data <= in_data;
    end
  end

  assign in_rdy   = !skid_vld;
  assign out_vld  = main_vld;
  assign out_data = main_data;

endmodule

// ==== design/body_write_stage.sv ====
/* Two-register write path. The strobe is single cycle, and the centering wraps modulo 2^16 */
`timescale 1ns/10ps

module body_write_stage (
  input  logic                                clk,
  input  logic                                s_rst_n,
  input  logic                                ks_wr_en,
  input  logic [lwe_param_pkg::MOD_KSK_W-1:0] ks_wr_data,
  input  logic [pbs_slot_pkg::PID_W-1:0]      ks_wr_pid,
  output logic                                wr_en,
  output logic [lwe_param_pkg::MOD_KSK_W-1:0] wr_data,
  output logic [pbs_slot_pkg::PID_W-1:0]      wr_pid
);

  logic                                s1_en;
  logic [lwe_param_pkg::MOD_KSK_W-1:0] s1_data;
  logic [pbs_slot_pkg::PID_W-1:0]      s1_pid;

  // --------------------------------------------------------------------------
  // Strobe pipe
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      s1_en <= 1'b0;
      wr_en <= 1'b0;
    end else begin
      s1_en <= ks_wr_en;
      wr_en <= s1_en;
    end
  end

  // Payload, centered in the second register
  always_ff @(posedge clk) begin
    s1_data <= ks_wr_data;
    s1_pid  <= ks_wr_pid;
    wr_data <= s1_data - lwe_param_pkg::CENTER_CORR;
    wr_pid  <= s1_pid;
  end

endmodule

// ==== design/body_store.sv ====
/* Body array with one presence bit per slot. A pid at or above PBS_NB is not stored */
`timescale 1ns/10ps

module body_store #(
  parameter int PBS_NB = 16
) (
  input  logic                                clk,
  input  logic                                s_rst_n,
  input  logic                                reset_cache,
  input  logic                                wr_en,
  input  logic [lwe_param_pkg::MOD_KSK_W-1:0] wr_data,
  input  logic [pbs_slot_pkg::PID_W-1:0]      wr_pid,
  slot_lookup_if.body                         lookup
);

  logic [lwe_param_pkg::MOD_KSK_W-1:0] body_mem [PBS_NB];
  logic [PBS_NB-1:0]                   present;

  // Depth limit of the slot numbering
  if (PBS_NB > pbs_slot_pkg::PBS_NB_MAX) begin : gen_depth_check
    $error("body_store depth %0d above slot limit", PBS_NB);
  end

  // --------------------------------------------------------------------------
  // Storage
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (wr_en) begin
      body_mem[wr_pid] <= wr_data;
    end
  end

  // Presence: cache reset clears all, write beats the read clear
  always_ff @(posedge clk) begin
    if (!s_rst_n || reset_cache) begin
      present <= '0;
    end else begin
      if (lookup.rd_en) begin
        present[lookup.rd_pid] <= 1'b0;
      end
      if (wr_en) begin
        present[wr_pid] <= 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Lookup answer
  // --------------------------------------------------------------------------
  assign lookup.body_data    = body_mem[lookup.rd_pid];
  assign lookup.body_present = present[lookup.rd_pid];
  // Scheduler holds off while the array is written
  assign lookup.body_wr_busy = wr_en;

  // Scheduler only consumes slots holding a body
  a_rd_present: assert property (@(posedge clk) disable iff (!s_rst_n)
    lookup.rd_en |-> lookup.body_present)
    else $error("body_store read of absent pid %0d", lookup.rd_pid);

endmodule

// ==== design/corr_accum.sv ====
/* Signed error sum per slot. At most LWE_K corrections may arrive per slot between reads */
`timescale 1ns/10ps

module corr_accum #(
  parameter int PBS_NB = 16
) (
  input  logic                                clk,
  input  logic                                s_rst_n,
  input  logic                                reset_cache,
  input  logic                                corr_wr_en,
  input  logic [lwe_param_pkg::KS_CORR_W-1:0] corr_wr_data,
  input  logic [pbs_slot_pkg::PID_W-1:0]      corr_wr_pid,
  slot_lookup_if.corr                         lookup
);

  localparam int SUM_W = lwe_param_pkg::KS_MAX_ERROR_W;
  localparam int CNT_W = pbs_slot_pkg::LWE_K_WW;

  logic                                wr_en_q;
  logic [lwe_param_pkg::KS_CORR_W-1:0] wr_data_q;
  logic [pbs_slot_pkg::PID_W-1:0]      wr_pid_q;

  logic [SUM_W-1:0]  sum_mem [PBS_NB];
  logic [CNT_W-1:0]  cnt_mem [PBS_NB];
  logic [PBS_NB-1:0] present;

  logic [SUM_W-1:0]  corr_ext;
  logic [SUM_W-1:0]  sum_next;
  logic [CNT_W-1:0]  cnt_next;
  logic              wr_hit;

  // --------------------------------------------------------------------------
  // Input register
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      wr_en_q <= 1'b0;
    end else begin
      wr_en_q <= corr_wr_en;
    end
  end

  always_ff @(posedge clk) begin
    wr_data_q <= corr_wr_data;
    wr_pid_q  <= corr_wr_pid;
  end

  // Sign extension of the small error term
  assign corr_ext = {{(SUM_W - lwe_param_pkg::KS_CORR_W){wr_data_q[lwe_param_pkg::KS_CORR_W-1]}},
                     wr_data_q};

  // First term restarts sum and count, later terms accumulate
  assign wr_hit   = present[wr_pid_q];
  assign sum_next = wr_hit ? sum_mem[wr_pid_q] + corr_ext : corr_ext;
  assign cnt_next = wr_hit ? CNT_W'(cnt_mem[wr_pid_q] + 1'b1) : CNT_W'(1);

  always_ff @(posedge clk) begin
    if (wr_en_q) begin
      sum_mem[wr_pid_q] <= sum_next;
      cnt_mem[wr_pid_q] <= cnt_next;
    end
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n || reset_cache) begin
      present <= '0;
    end else begin
      if (lookup.rd_en) begin
        present[lookup.rd_pid] <= 1'b0;
      end
      if (wr_en_q) begin
        present[wr_pid_q] <= 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Lookup answer
  // --------------------------------------------------------------------------
  assign lookup.corr_sum     = sum_mem[lookup.rd_pid];
  assign lookup.corr_avail   = present[lookup.rd_pid]
                               && (cnt_mem[lookup.rd_pid] == CNT_W'(pbs_slot_pkg::LWE_K));
  assign lookup.corr_wr_busy = wr_en_q;

  // Sequencer never sends more than LWE_K terms before the read
  a_no_overflow: assert property (@(posedge clk) disable iff (!s_rst_n)
    wr_en_q && wr_hit |-> cnt_mem[wr_pid_q] < CNT_W'(pbs_slot_pkg::LWE_K))
    else $error("corr_accum extra correction at pid %0d", wr_pid_q);

endmodule

// ==== design/slot_read_sched.sv ====
/* Requests leave in order. A request for an incomplete slot blocks all later ones */
`timescale 1ns/10ps

module slot_read_sched (
  input  logic                                clk,
  input  logic                                s_rst_n,
  input  logic [pbs_slot_pkg::PID_W-1:0]      rd_pid,
  input  logic                                rd_vld,
  output logic                                rd_rdy,
  slot_lookup_if.sched                        lookup,
  output logic [lwe_param_pkg::MOD_KSK_W+lwe_param_pkg::KS_MAX_ERROR_W-1:0] mid_data,
  output logic                                mid_vld,
  input  logic                                mid_rdy
);

  localparam int MID_W = lwe_param_pkg::MOD_KSK_W + lwe_param_pkg::KS_MAX_ERROR_W;

  logic [pbs_slot_pkg::PID_W-1:0] s0_pid;
  logic                           s0_vld;
  logic                           s0_rdy;
  logic                           rd_cond;
  logic                           mid_in_vld;
  logic                           mid_in_rdy;

  skid_buffer #(.WIDTH(pbs_slot_pkg::PID_W)) in_buf (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .in_data  (rd_pid),
    .in_vld   (rd_vld),
    .in_rdy   (rd_rdy),
    .out_data (s0_pid),
    .out_vld  (s0_vld),
    .out_rdy  (s0_rdy)
  );

  // Slot complete and no write racing the read clear
  assign lookup.rd_pid = s0_pid;
  assign rd_cond       = lookup.body_present && lookup.corr_avail
                         && !lookup.body_wr_busy && !lookup.corr_wr_busy;
  assign mid_in_vld    = s0_vld && rd_cond;
  assign s0_rdy        = mid_in_rdy && rd_cond;
  assign lookup.rd_en  = mid_in_vld && mid_in_rdy;

  // Timing stage in front of the compensation
  skid_buffer #(.WIDTH(MID_W)) mid_buf (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .in_data  ({lookup.corr_sum, lookup.body_data}),
    .in_vld   (mid_in_vld),
    .in_rdy   (mid_in_rdy),
    .out_data (mid_data),
    .out_vld  (mid_vld),
    .out_rdy  (mid_rdy)
  );

endmodule

// ==== design/mean_comp_modswitch.sv ====
/* Result is body*2^F minus sum*mean, modulo 2^BR_CORR_W. The rounded coefficient wraps on overflow */
`timescale 1ns/10ps

module mean_comp_modswitch (
  input  logic [lwe_param_pkg::MOD_KSK_W+lwe_param_pkg::KS_MAX_ERROR_W-1:0] mid_data,
  input  logic                                 mid_vld,
  output logic                                 mid_rdy,
  output logic [lwe_param_pkg::LWE_COEF_W-1:0] out_data,
  output logic                                 out_vld,
  input  logic                                 out_rdy
);

  localparam int BR_W  = lwe_param_pkg::BR_CORR_W;
  localparam int SUM_W = lwe_param_pkg::KS_MAX_ERROR_W;

  logic [lwe_param_pkg::MOD_KSK_W-1:0] body;
  logic [SUM_W-1:0]                    sum;
  logic [BR_W-1:0]                     sum_ext;
  lwe_param_pkg::br_word_u             br;

  assign {sum, body} = mid_data;
  assign sum_ext     = {{(BR_W - SUM_W){sum[SUM_W-1]}}, sum};

  // Body to fixed point, then remove mean times error sum
  assign br.word = (BR_W'(body) << lwe_param_pkg::KS_KEY_MEAN_F)
                   - sum_ext * BR_W'(lwe_param_pkg::KS_KEY_MEAN);

  // Top bits are the coefficient whatever the fraction point
  assign out_data = br.fields.coef + lwe_param_pkg::LWE_COEF_W'(br.fields.round_bit);

  assign out_vld = mid_vld;
  assign mid_rdy = out_rdy;

endmodule

// ==== design/body_ram_top.sv ====
/* Body store of the sample-extract front end. PBS_NB up to PBS_NB_MAX, pids below PBS_NB */
`timescale 1ns/10ps

module body_ram_top #(
  parameter int PBS_NB = 16
) (
  input  logic                                 clk,
  input  logic                                 s_rst_n,
  input  logic                                 reset_cache,
  input  logic                                 ks_wr_en,
  input  logic [lwe_param_pkg::MOD_KSK_W-1:0]  ks_wr_data,
  input  logic [pbs_slot_pkg::PID_W-1:0]       ks_wr_pid,
  input  logic                                 corr_wr_en,
  input  logic [lwe_param_pkg::KS_CORR_W-1:0]  corr_wr_data,
  input  logic [pbs_slot_pkg::PID_W-1:0]       corr_wr_pid,
  input  logic [pbs_slot_pkg::PID_W-1:0]       rd_pid,
  input  logic                                 rd_vld,
  output logic                                 rd_rdy,
  output logic [lwe_param_pkg::LWE_COEF_W-1:0] sxt_data,
  output logic                                 sxt_vld,
  input  logic                                 sxt_rdy
);

  localparam int MID_W = lwe_param_pkg::MOD_KSK_W + lwe_param_pkg::KS_MAX_ERROR_W;

  logic                                 wr_en;
  logic [lwe_param_pkg::MOD_KSK_W-1:0]  wr_data;
  logic [pbs_slot_pkg::PID_W-1:0]       wr_pid;
  logic [MID_W-1:0]                     mid_data;
  logic                                 mid_vld;
  logic                                 mid_rdy;
  logic [lwe_param_pkg::LWE_COEF_W-1:0] comp_data;
  logic                                 comp_vld;
  logic                                 comp_rdy;

  slot_lookup_if lookup ();

  // --------------------------------------------------------------------------
  // Write side
  // --------------------------------------------------------------------------
  body_write_stage body_write_stage_i (
    .clk (clk), .s_rst_n (s_rst_n),
    .ks_wr_en (ks_wr_en), .ks_wr_data (ks_wr_data), .ks_wr_pid (ks_wr_pid),
    .wr_en (wr_en), .wr_data (wr_data), .wr_pid (wr_pid)
  );

  body_store #(.PBS_NB(PBS_NB)) body_store_i (
    .clk (clk), .s_rst_n (s_rst_n), .reset_cache (reset_cache),
    .wr_en (wr_en), .wr_data (wr_data), .wr_pid (wr_pid),
    .lookup (lookup.body)
  );

  corr_accum #(.PBS_NB(PBS_NB)) corr_accum_i (
    .clk (clk), .s_rst_n (s_rst_n), .reset_cache (reset_cache),
    .corr_wr_en (corr_wr_en), .corr_wr_data (corr_wr_data), .corr_wr_pid (corr_wr_pid),
    .lookup (lookup.corr)
  );

  // --------------------------------------------------------------------------
  // Read side
  // --------------------------------------------------------------------------
  slot_read_sched slot_read_sched_i (
    .clk (clk), .s_rst_n (s_rst_n),
    .rd_pid (rd_pid), .rd_vld (rd_vld), .rd_rdy (rd_rdy),
    .lookup (lookup.sched),
    .mid_data (mid_data), .mid_vld (mid_vld), .mid_rdy (mid_rdy)
  );

  mean_comp_modswitch mean_comp_modswitch_i (
    .mid_data (mid_data), .mid_vld (mid_vld), .mid_rdy (mid_rdy),
    .out_data (comp_data), .out_vld (comp_vld), .out_rdy (comp_rdy)
  );

  skid_buffer #(.WIDTH(lwe_param_pkg::LWE_COEF_W)) out_buf (
    .clk (clk), .s_rst_n (s_rst_n),
    .in_data (comp_data), .in_vld (comp_vld), .in_rdy (comp_rdy),
    .out_data (sxt_data), .out_vld (sxt_vld), .out_rdy (sxt_rdy)
  );

endmodule

// ==== include/tb_body_model.svh ====
/* Bench model, included inside the testbench module. Both packages must be compiled first */
`ifndef TB_BODY_MODEL_SVH
`define TB_BODY_MODEL_SVH

// Galois LFSR state, taps x^8+x^6+x^5+x^4+1
logic [7:0] lfsr_q = 8'd85;

// Expected sxt_data, one per accepted request
logic [lwe_param_pkg::LWE_COEF_W-1:0] exp_q [$];

function automatic logic lfsr_bit();
  logic b;
  b      = lfsr_q[0];
  lfsr_q = lfsr_q >> 1;
  if (b) begin
    lfsr_q = lfsr_q ^ 8'hB8;
  end
  return b;
endfunction

// One LFSR step per bit taken, MSB first
function automatic logic [31:0] lfsr_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsr_bit()};
  end
  return v;
endfunction

// Reference formula on the raw body and the signed correction sum
function automatic logic [lwe_param_pkg::LWE_COEF_W-1:0] model_sxt(
  input logic [lwe_param_pkg::MOD_KSK_W-1:0] body, input int corr_sum);
  logic [lwe_param_pkg::MOD_KSK_W-1:0] centered;
  logic [lwe_param_pkg::BR_CORR_W-1:0] comp;
  centered = body - lwe_param_pkg::CENTER_CORR;
  comp     = (lwe_param_pkg::BR_CORR_W'(centered) << lwe_param_pkg::KS_KEY_MEAN_F)
             - lwe_param_pkg::BR_CORR_W'(corr_sum * lwe_param_pkg::KS_KEY_MEAN);
  return comp[lwe_param_pkg::BR_CORR_W-1 -: lwe_param_pkg::LWE_COEF_W]
         + comp[lwe_param_pkg::BR_CORR_W-1-lwe_param_pkg::LWE_COEF_W];
endfunction

`endif

// ==== bench/tb_body_ram_top.sv ====
/* Bench for body_ram_top with PBS_NB at 16. Reads leave in request order, so one queue
   of expected words covers all traffic */
`timescale 1ns/10ps

module tb_body_ram_top;

  localparam int CLK_PERIOD = 10;
  localparam int NUM_REQ    = 18;
  localparam int WAIT_LIMIT = 200;
  localparam int PID_W      = pbs_slot_pkg::PID_W;
  localparam int BODY_W     = lwe_param_pkg::MOD_KSK_W;
  localparam int CORR_W     = lwe_param_pkg::KS_CORR_W;
  localparam int COEF_W     = lwe_param_pkg::LWE_COEF_W;

  logic              clk;
  logic              s_rst_n;
  logic              reset_cache;
  logic              ks_wr_en;
  logic [BODY_W-1:0] ks_wr_data;
  logic [PID_W-1:0]  ks_wr_pid;
  logic              corr_wr_en;
  logic [CORR_W-1:0] corr_wr_data;
  logic [PID_W-1:0]  corr_wr_pid;
  logic [PID_W-1:0]  rd_pid;
  logic              rd_vld;
  logic              rd_rdy;
  logic [COEF_W-1:0] sxt_data;
  logic              sxt_vld;
  logic              sxt_rdy;

  // Run state seen by the assertions
  string             test_name    = "reset";
  int                err_data     = 0;
  int                err_proto    = 0;
  int                exp_cnt      = 0;
  logic [COEF_W-1:0] exp_head     = '0;
  logic              stall_window = 1'b0;
  logic              bp_active    = 1'b0;
  logic              saw_rdy_low  = 1'b0;

  `include "tb_body_model.svh"

  body_ram_top #(.PBS_NB(16)) body_ram_top_i (
    .clk (clk), .s_rst_n (s_rst_n), .reset_cache (reset_cache),
    .ks_wr_en (ks_wr_en), .ks_wr_data (ks_wr_data), .ks_wr_pid (ks_wr_pid),
    .corr_wr_en (corr_wr_en), .corr_wr_data (corr_wr_data), .corr_wr_pid (corr_wr_pid),
    .rd_pid (rd_pid), .rd_vld (rd_vld), .rd_rdy (rd_rdy),
    .sxt_data (sxt_data), .sxt_vld (sxt_vld), .sxt_rdy (sxt_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  a_data: assert property (@(posedge clk) disable iff (!s_rst_n)
    sxt_vld && sxt_rdy && exp_cnt != 0 |-> sxt_data == exp_head)
    else begin
      err_data++;
      $display("FAIL %s expected %0d actual %0d", test_name, $sampled(exp_head),
               $sampled(sxt_data));
    end

  a_pending: assert property (@(posedge clk) disable iff (!s_rst_n)
    sxt_vld && sxt_rdy |-> exp_cnt != 0)
    else begin
      err_proto++;
      $display("%s: output word with no request pending", test_name);
    end

  a_stable: assert property (@(posedge clk) disable iff (!s_rst_n)
    sxt_vld && !sxt_rdy |=> sxt_vld && $stable(sxt_data))
    else begin
      err_proto++;
      $display("%s: stalled output changed before it was taken", test_name);
    end

  // Incomplete or flushed slot must not produce output
  a_stall: assert property (@(posedge clk) disable iff (!s_rst_n)
    stall_window |-> !sxt_vld)
    else begin
      err_proto++;
      $display("%s: output appeared for an incomplete slot", test_name);
    end

  a_reset_idle: assert property (@(posedge clk) !s_rst_n |=> !sxt_vld)
    else begin
      err_proto++;
      $display("sxt_vld high during or right after reset");
    end

  // Scoreboard pop on each output transfer
  always @(posedge clk) begin
    if (s_rst_n && sxt_vld && sxt_rdy && exp_q.size() != 0) begin
      void'(exp_q.pop_front());
      refresh_head();
    end
    if (bp_active && !rd_rdy) begin
      saw_rdy_low = 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------------------------------
  task automatic refresh_head();
    exp_cnt  = exp_q.size();
    exp_head = (exp_cnt != 0) ? exp_q[0] : '0;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  // Sum of the four signed error terms, packed low nibble first
  function automatic int corr_total(input logic [4*CORR_W-1:0] corrs);
    int s;
    s = 0;
    for (int i = 0; i < 4; i++) begin
      s += int'($signed(corrs[i*CORR_W +: CORR_W]));
    end
    return s;
  endfunction

  task automatic write_cycle(input logic body_en, input logic [PID_W-1:0] pid,
                             input logic [BODY_W-1:0] body, input logic corr_en,
                             input logic [CORR_W-1:0] corr);
    ks_wr_en     = body_en;
    ks_wr_pid    = pid;
    ks_wr_data   = body;
    corr_wr_en   = corr_en;
    corr_wr_pid  = pid;
    corr_wr_data = corr;
    next_cycle();
    ks_wr_en     = 1'b0;
    corr_wr_en   = 1'b0;
  endtask

  // Body with the first correction, then the next n-1 corrections
  task automatic fill_slot(input logic [PID_W-1:0] pid, input logic [BODY_W-1:0] body,
                           input logic [4*CORR_W-1:0] corrs, input int n);
    write_cycle(1'b1, pid, body, 1'b1, corrs[CORR_W-1:0]);
    for (int i = 1; i < n; i++) begin
      write_cycle(1'b0, pid, body, 1'b1, corrs[i*CORR_W +: CORR_W]);
    end
  endtask

  task automatic request(input logic [PID_W-1:0] pid, input logic [COEF_W-1:0] expected);
    logic taken;
    int   n;
    exp_q.push_back(expected);
    refresh_head();
    rd_pid = pid;
    rd_vld = 1'b1;
    n      = 0;
    do begin
      taken = rd_rdy;
      next_cycle();
      n++;
    end while (!taken && n < WAIT_LIMIT);
    rd_vld = 1'b0;
    if (!taken) begin
      err_proto++;
      $display("%s: request for pid %0d was never accepted", test_name, pid);
    end
  endtask

  task automatic wait_drained(input int limit);
    int n;
    n = 0;
    while (exp_cnt != 0 && n < limit) begin
      next_cycle();
      n++;
    end
    if (exp_cnt != 0) begin
      err_proto++;
      $display("%s: %0d outputs missing after %0d cycles", test_name, exp_cnt, limit);
    end
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    logic [PID_W-1:0]    pid;
    logic [BODY_W-1:0]   body;
    logic [BODY_W-1:0]   new_body;
    logic [4*CORR_W-1:0] corrs;
    logic [4*CORR_W-1:0] new_corrs;
    logic [COEF_W-1:0]   exp_bp [8];

    s_rst_n      = 1'b0;
    reset_cache  = 1'b0;
    ks_wr_en     = 1'b0;
    ks_wr_data   = '0;
    ks_wr_pid    = '0;
    corr_wr_en   = 1'b0;
    corr_wr_data = '0;
    corr_wr_pid  = '0;
    rd_pid       = '0;
    rd_vld       = 1'b0;
    sxt_rdy      = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    s_rst_n = 1'b1;

    // First round uses fixed terms -8, +1, -1, -8
    test_name = "basic_read";
    for (int i = 0; i < 8; i++) begin
      pid   = PID_W'(lfsr_bits(PID_W));
      body  = BODY_W'(lfsr_bits(BODY_W));
      corrs = (i == 0) ? 16'h8F18 : 16'(lfsr_bits(4 * CORR_W));
      fill_slot(pid, body, corrs, 4);
      request(pid, model_sxt(body, corr_total(corrs)));
      wait_drained(WAIT_LIMIT);
    end

    // Fourth term held back while the request sits in the scheduler
    test_name = "read_waits";
    pid   = PID_W'(lfsr_bits(PID_W));
    body  = BODY_W'(lfsr_bits(BODY_W));
    corrs = 16'(lfsr_bits(4 * CORR_W));
    fill_slot(pid, body, corrs, 3);
    wait_cycles(4);
    request(pid, model_sxt(body, corr_total(corrs)));
    stall_window = 1'b1;
    wait_cycles(20);
    stall_window = 1'b0;
    write_cycle(1'b0, pid, body, 1'b1, corrs[3*CORR_W +: CORR_W]);
    wait_drained(WAIT_LIMIT);

    // Eight reads against six buffer entries, so the input must stall
    test_name = "back_pressure";
    for (int i = 0; i < 8; i++) begin
      body      = BODY_W'(lfsr_bits(BODY_W));
      corrs     = 16'(lfsr_bits(4 * CORR_W));
      exp_bp[i] = model_sxt(body, corr_total(corrs));
      fill_slot(PID_W'(8 + i), body, corrs, 4);
    end
    sxt_rdy   = 1'b0;
    bp_active = 1'b1;
    fork
      begin
        for (int i = 0; i < 8; i++) begin
          request(PID_W'(8 + i), exp_bp[i]);
        end
      end
      begin
        wait_cycles(40);
        sxt_rdy = 1'b1;
      end
    join
    bp_active = 1'b0;
    wait_drained(WAIT_LIMIT);

    // Flushed slot stalls until it is written again
    test_name = "cache_reset";
    pid   = PID_W'(lfsr_bits(PID_W));
    body  = BODY_W'(lfsr_bits(BODY_W));
    corrs = 16'(lfsr_bits(4 * CORR_W));
    fill_slot(pid, body, corrs, 4);
    wait_cycles(4);
    reset_cache = 1'b1;
    next_cycle();
    reset_cache = 1'b0;
    new_body  = BODY_W'(lfsr_bits(BODY_W));
    new_corrs = 16'(lfsr_bits(4 * CORR_W));
    request(pid, model_sxt(new_body, corr_total(new_corrs)));
    stall_window = 1'b1;
    wait_cycles(20);
    stall_window = 1'b0;
    fill_slot(pid, new_body, new_corrs, 4);
    wait_drained(WAIT_LIMIT);

    test_name = "final";
    assert (saw_rdy_low) else begin
      err_proto++;
      $display("rd_rdy never dropped while the output was stalled");
    end
    assert (exp_cnt == 0) else begin
      err_proto++;
      $display("%0d expected outputs never arrived", exp_cnt);
    end
    $display("errors: data %0d, protocol %0d", err_data, err_proto);
    if (err_data + err_proto == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Watchdog sized for the request count
  initial begin
    #(CLK_PERIOD * WAIT_LIMIT * NUM_REQ);
    $display("watchdog expired before the test sequence finished");
    $display("tests failed");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+include
design/lwe_param_pkg.sv
design/pbs_slot_pkg.sv
design/slot_lookup_if.sv
design/skid_buffer.sv
design/body_write_stage.sv
design/body_store.sv
design/corr_accum.sv
design/slot_read_sched.sv
design/mean_comp_modswitch.sv
design/body_ram_top.sv
bench/tb_body_ram_top.sv
